// ==== graph_ctrl.f ====
design/graph_pkg.sv
design/job_fifo.sv
design/rr_arbiter.sv
design/vertex_cu.sv
design/read_data_router.sv
design/progress_counters.sv
design/graph_ctrl.sv
tb/graph_ctrl_asserts.sv
tb/tb_graph_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the graph_ctrl testbench with Verilator and run it.
# The exit status of the simulation binary decides pass or fail.
# The runtime error limit lets the testbench see an assertion error
# and end the run through its own failure path.

cd "$(dirname "$0")" &&
verilator --binary -sv --assert -Wno-fatal \
	--top-module tb_graph_ctrl \
	-f graph_ctrl.f \
	-o sim_graph_ctrl &&
./obj_dir/sim_graph_ctrl +verilator+error+limit+100 &&
echo "run_sim: simulation ended with status 0" ||
{ echo "run_sim: build or simulation returned an error"; exit 1; }

// ==== tb/tb_graph_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_graph_ctrl
	import graph_pkg::*;
();

	localparam int NUM_JOBS       = 40;
	localparam int MAX_EDGES      = 6;
	localparam int IDLE_LIMIT     = 100;
	localparam int TIMEOUT_CYCLES = NUM_JOBS * MAX_EDGES * READ_PERIOD * 2 + 2000;

	logic                  clock;
	logic                  rstn;
	logic                  enable;
	logic [CU_ID_W:0]      active_cus;
	logic                  job_valid;
	logic [VERTEX_W-1:0]   job_vertex;
	logic [ADDR_W-1:0]     job_edge_start;
	logic [EDGE_CNT_W-1:0] job_edge_count;
	logic                  job_ready;
	logic                  rd_cmd_valid;
	logic [ADDR_W-1:0]     rd_cmd_addr;
	logic [CU_ID_W-1:0]    rd_cmd_cu_id;
	logic                  rd_cmd_stall;
	logic                  rd_resp_valid;
	logic [CU_ID_W-1:0]    rd_resp_cu_id;
	logic [DONE_W-1:0]     vertex_done_count;
	logic [DONE_W-1:0]     edge_done_count;

	int pushed_edges = 0;
	int cycle_count  = 0;
	int idle_cycles  = 0;
	int cmds_seen    = 0;

	// Outstanding reads of the memory model
	logic [CU_ID_W-1:0] pend_cu [$];
	int                 pend_due [$];

	// Edge addresses of pushed jobs not yet read
	logic [ADDR_W-1:0] exp_addr [$];

	graph_ctrl #(
		.NUM_CU   (NUM_CU_DEFAULT),
		.JOB_DEPTH(JOB_DEPTH_DEFAULT),
		.CMD_DEPTH(CMD_DEPTH_DEFAULT)
	) i_dut (
		.clock            (clock),
		.rstn             (rstn),
		.enable           (enable),
		.active_cus       (active_cus),
		.job_valid        (job_valid),
		.job_vertex       (job_vertex),
		.job_edge_start   (job_edge_start),
		.job_edge_count   (job_edge_count),
		.job_ready        (job_ready),
		.rd_cmd_valid     (rd_cmd_valid),
		.rd_cmd_addr      (rd_cmd_addr),
		.rd_cmd_cu_id     (rd_cmd_cu_id),
		.rd_cmd_stall     (rd_cmd_stall),
		.rd_resp_valid    (rd_resp_valid),
		.rd_resp_cu_id    (rd_resp_cu_id),
		.vertex_done_count(vertex_done_count),
		.edge_done_count  (edge_done_count)
	);

	always #2 clock = ~clock;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on error");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Host side job stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic push_jobs();
		int                pushed;
		int                edges;
		bit                paused;
		logic [ADDR_W-1:0] start;
		pushed = 0;
		paused = 1'b0;
		while (pushed < NUM_JOBS) begin
			@(posedge clock);
			// Second half runs on all four CUs
			if (pushed >= NUM_JOBS / 2) begin
				active_cus <= (CU_ID_W + 1)'(4);
			end
			if (pushed == 10 && !paused) begin
				job_valid <= 1'b0;
				enable    <= 1'b0;
				repeat (20) @(posedge clock);
				enable <= 1'b1;
				paused = 1'b1;
			end else if (job_ready) begin
				edges = $urandom_range(0, MAX_EDGES);
				start = $urandom;
				job_valid      <= 1'b1;
				job_vertex     <= VERTEX_W'(pushed);
				job_edge_start <= start;
				job_edge_count <= EDGE_CNT_W'(edges);
				// One read per edge, at consecutive addresses
				for (int k = 0; k < edges; k++) begin
					exp_addr.push_back(start + ADDR_W'(k));
				end
				pushed_edges = pushed_edges + edges;
				pushed++;
			end else begin
				job_valid <= 1'b0;
			end
		end
		@(posedge clock);
		job_valid <= 1'b0;
	endtask

	task automatic wait_for_idle();
		while (idle_cycles < IDLE_LIMIT) begin
			@(posedge clock);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory model with random latency and stall
	//////////////////////////////////////////////////////////////////////

	always @(posedge clock) begin : memory_model
		int hit;
		int match;
		hit = -1;
		for (int i = 0; i < pend_cu.size(); i++) begin
			if (hit < 0 && pend_due[i] <= cycle_count) begin
				hit = i;
			end
		end
		if (hit >= 0) begin
			rd_resp_valid <= 1'b1;
			rd_resp_cu_id <= pend_cu[hit];
			pend_cu.delete(hit);
			pend_due.delete(hit);
		end else begin
			rd_resp_valid <= 1'b0;
		end
		if (rd_cmd_valid) begin
			match = -1;
			for (int i = 0; i < exp_addr.size(); i++) begin
				if (match < 0 && exp_addr[i] == rd_cmd_addr) begin
					match = i;
				end
			end
			if (match < 0) begin
				$display("** Error at %0t ns: read address %h matches no pending edge",
					$time, rd_cmd_addr);
				abort_run("Read command address is wrong");
			end else begin
				exp_addr.delete(match);
			end
			pend_cu.push_back(rd_cmd_cu_id);
			pend_due.push_back(cycle_count + int'($urandom_range(1, 10)));
			cmds_seen <= cmds_seen + 1;
		end
		if (rstn) begin
			rd_cmd_stall <= ($urandom_range(0, 3) == 0);
		end
		if (rd_cmd_valid || hit >= 0 || pend_cu.size() != 0) begin
			idle_cycles <= 0;
		end else if (idle_cycles < IDLE_LIMIT) begin
			idle_cycles <= idle_cycles + 1;
		end
	end

	// Run limit
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			abort_run("Timeout: the jobs did not complete within the cycle limit");
		end
	end

	always @(negedge clock) begin
		if (i_dut.u_asserts.error_count != 0) begin
			abort_run("A protocol assertion on graph_ctrl failed");
		end
	end

	initial begin
		void'($urandom(43));
		clock          = 1'b0;
		rstn           = 1'b0;
		enable         = 1'b1;
		active_cus     = (CU_ID_W + 1)'(3);
		job_valid      = 1'b0;
		job_vertex     = '0;
		job_edge_start = '0;
		job_edge_count = '0;
		rd_cmd_stall   = 1'b0;
		rd_resp_valid  = 1'b0;
		rd_resp_cu_id  = '0;
		repeat (5) @(posedge clock);
		rstn <= 1'b1;
		push_jobs();
		wait_for_idle();
		// Totals against what was pushed and what the memory saw
		if (vertex_done_count != DONE_W'(NUM_JOBS)) begin
			$display("** Error at %0t ns: vertex_done_count is %0d, expected %0d",
				$time, vertex_done_count, NUM_JOBS);
			abort_run("Final vertex total is wrong");
		end else if (edge_done_count != DONE_W'(pushed_edges)) begin
			$display("** Error at %0t ns: edge_done_count is %0d, expected %0d",
				$time, edge_done_count, pushed_edges);
			abort_run("Final edge total is wrong");
		end else if (cmds_seen != pushed_edges) begin
			$display("** Error at %0t ns: %0d read commands seen, expected %0d",
				$time, cmds_seen, pushed_edges);
			abort_run("Read command count is wrong");
		end else begin
			$display("=== PASS ===");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb/graph_ctrl_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module graph_ctrl_asserts
	import graph_pkg::*;
(
	input logic               clock,
	input logic               rstn,
	input logic               enable,
	input logic [CU_ID_W:0]   active_cus,
	input logic               job_valid,
	input logic               job_ready,
	input logic               rd_cmd_valid,
	input logic [CU_ID_W-1:0] rd_cmd_cu_id,
	input logic               rd_cmd_stall,
	input logic               rd_resp_valid,
	input logic [DONE_W-1:0]  vertex_done_count,
	input logic [DONE_W-1:0]  edge_done_count
);

	int   error_count = 0;
	logic seen_job;
	int   cmd_gap;
	int   resp_total;

	// Cycles since the last command, saturating at the read slot period
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			seen_job   <= 1'b0;
			cmd_gap    <= READ_PERIOD;
			resp_total <= 0;
		end else begin
			if (job_valid) begin
				seen_job <= 1'b1;
			end
			if (rd_cmd_valid) begin
				cmd_gap <= 1;
			end else if (cmd_gap < READ_PERIOD) begin
				cmd_gap <= cmd_gap + 1;
			end
			if (rd_resp_valid) begin
				resp_total <= resp_total + 1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Protocol and result properties
	//////////////////////////////////////////////////////////////////////

	// Quiet outputs until the host offers its first job
	a_idle_after_reset: assert property (@(posedge clock) disable iff (!rstn)
		!seen_job |-> (!rd_cmd_valid && vertex_done_count == '0 &&
			edge_done_count == '0 && job_ready))
		else begin
			$error("outputs not in reset state before the first job");
			error_count = error_count + 1;
		end

	a_stall_respected: assert property (@(posedge clock) disable iff (!rstn)
		$past(rd_cmd_stall) |-> !rd_cmd_valid)
		else begin
			$error("rd_cmd_valid high in the cycle after rd_cmd_stall");
			error_count = error_count + 1;
		end

	a_cmd_spacing: assert property (@(posedge clock) disable iff (!rstn)
		rd_cmd_valid |-> (cmd_gap >= READ_PERIOD))
		else begin
			$error("two read commands closer than the read slot period");
			error_count = error_count + 1;
		end

	a_cu_id_active: assert property (@(posedge clock) disable iff (!rstn)
		rd_cmd_valid |-> ({1'b0, rd_cmd_cu_id} < active_cus))
		else begin
			$error("read command from a CU above active_cus");
			error_count = error_count + 1;
		end

	// Frozen for two cycles means no commands and no counting
	a_enable_freeze: assert property (@(posedge clock) disable iff (!rstn)
		(!enable && !$past(enable)) |-> (!rd_cmd_valid &&
			vertex_done_count == $past(vertex_done_count) &&
			edge_done_count == $past(edge_done_count)))
		else begin
			$error("controller active while enable is low");
			error_count = error_count + 1;
		end

	a_counts_monotonic: assert property (@(posedge clock) disable iff (!rstn)
		(vertex_done_count >= $past(vertex_done_count)) &&
		(edge_done_count >= $past(edge_done_count)))
		else begin
			$error("a done count decreased");
			error_count = error_count + 1;
		end

	a_edges_bounded: assert property (@(posedge clock) disable iff (!rstn)
		edge_done_count <= DONE_W'(resp_total))
		else begin
			$error("edge_done_count above the number of read responses");
			error_count = error_count + 1;
		end

endmodule

bind graph_ctrl graph_ctrl_asserts u_asserts (
	.clock            (clock),
	.rstn             (rstn),
	.enable           (enable),
	.active_cus       (active_cus),
	.job_valid        (job_valid),
	.job_ready        (job_ready),
	.rd_cmd_valid     (rd_cmd_valid),
	.rd_cmd_cu_id     (rd_cmd_cu_id),
	.rd_cmd_stall     (rd_cmd_stall),
	.rd_resp_valid    (rd_resp_valid),
	.vertex_done_count(vertex_done_count),
	.edge_done_count  (edge_done_count)
);

`default_nettype wire

// ==== design/graph_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module graph_ctrl
	import graph_pkg::*;
#(
	parameter int NUM_CU    = NUM_CU_DEFAULT,
	parameter int JOB_DEPTH = JOB_DEPTH_DEFAULT,
	parameter int CMD_DEPTH = CMD_DEPTH_DEFAULT
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enable,
	input  logic [CU_ID_W:0]      active_cus,
	input  logic                  job_valid,
	input  logic [VERTEX_W-1:0]   job_vertex,
	input  logic [ADDR_W-1:0]     job_edge_start,
	input  logic [EDGE_CNT_W-1:0] job_edge_count,
	output logic                  job_ready,
	output logic                  rd_cmd_valid,
	output logic [ADDR_W-1:0]     rd_cmd_addr,
	output logic [CU_ID_W-1:0]    rd_cmd_cu_id,
	input  logic                  rd_cmd_stall,
	input  logic                  rd_resp_valid,
	input  logic [CU_ID_W-1:0]    rd_resp_cu_id,
	output logic [DONE_W-1:0]     vertex_done_count,
	output logic [DONE_W-1:0]     edge_done_count
);

	vertex_job_t                  job_in;
	vertex_job_t                  job_head;
	logic                         job_empty;
	logic                         job_almost_full;
	logic [NUM_CU-1:0]            active_mask;
	logic [NUM_CU-1:0]            cu_job_req;
	logic [NUM_CU-1:0]            job_elig;
	logic [NUM_CU-1:0]            job_grant;
	logic [NUM_CU-1:0]            cu_cmd_valid;
	logic [ADDR_W-1:0]            cu_cmd_addr [NUM_CU];
	logic [NUM_CU-1:0]            cu_cmd_full;
	logic [NUM_CU-1:0]            cmd_empty;
	read_cmd_t                    cmd_head [NUM_CU];
	logic [NUM_CU-1:0]            rd_req;
	logic [NUM_CU-1:0]            rd_grant;
	read_cmd_t                    sel_cmd;
	logic [NUM_CU-1:0]            cu_resp_valid;
	logic [NUM_CU-1:0]            cu_done;
	logic [NUM_CU*EDGE_CNT_W-1:0] cu_done_edges;

	//////////////////////////////////////////////////////////////////////
	// Job buffer and dispatch
	//////////////////////////////////////////////////////////////////////

	assign job_in.vertex     = job_vertex;
	assign job_in.edge_start = job_edge_start;
	assign job_in.edge_count = job_edge_count;

	// Two free entries cover a push already on its way
	assign job_ready = !job_almost_full;

	job_fifo #(
		.payload_t(vertex_job_t),
		.DEPTH    (JOB_DEPTH)
	) u_job_fifo (
		.clock      (clock),
		.rstn       (rstn),
		.push       (job_valid),
		.data_in    (job_in),
		.pop        (|job_grant),
		.data_out   (job_head),
		.full       (),
		.almost_full(job_almost_full),
		.empty      (job_empty)
	);

	// Only CUs below the run-time limit take part
	always_comb begin
		for (int i = 0; i < NUM_CU; i++) begin
			active_mask[i] = ((CU_ID_W + 1)'(i) < active_cus);
		end
	end

	assign job_elig = active_mask & cu_job_req & {NUM_CU{!job_empty}};

	rr_arbiter #(
		.N          (NUM_CU),
		.SLOT_PERIOD(DISPATCH_PERIOD)
	) u_dispatch_arb (
		.clock   (clock),
		.rstn    (rstn),
		.enable  (enable),
		.requests(job_elig),
		.grant   (job_grant)
	);

	//////////////////////////////////////////////////////////////////////
	// Compute units with their command FIFOs
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_CU; i++) begin : g_cu
		read_cmd_t cmd_in;

		assign cmd_in.addr  = cu_cmd_addr[i];
		assign cmd_in.cu_id = CU_ID_W'(i);

		vertex_cu u_cu (
			.clock     (clock),
			.rstn      (rstn),
			.enable    (enable),
			.job_req   (cu_job_req[i]),
			.job_grant (job_grant[i]),
			.job       (job_head),
			.cmd_valid (cu_cmd_valid[i]),
			.cmd_addr  (cu_cmd_addr[i]),
			.cmd_full  (cu_cmd_full[i]),
			.resp_valid(cu_resp_valid[i]),
			.done      (cu_done[i]),
			.done_edges(cu_done_edges[i*EDGE_CNT_W +: EDGE_CNT_W])
		);

		job_fifo #(
			.payload_t(read_cmd_t),
			.DEPTH    (CMD_DEPTH)
		) u_cmd_fifo (
			.clock      (clock),
			.rstn       (rstn),
			.push       (cu_cmd_valid[i]),
			.data_in    (cmd_in),
			.pop        (rd_grant[i]),
			.data_out   (cmd_head[i]),
			.full       (cu_cmd_full[i]),
			.almost_full(),
			.empty      (cmd_empty[i])
		);
	end

	//////////////////////////////////////////////////////////////////////
	// Read command merge onto the memory port
	//////////////////////////////////////////////////////////////////////

	// Stall seen now blocks the command of the next cycle
	assign rd_req = active_mask & ~cmd_empty & {NUM_CU{!rd_cmd_stall}};

	rr_arbiter #(
		.N          (NUM_CU),
		.SLOT_PERIOD(READ_PERIOD)
	) u_read_arb (
		.clock   (clock),
		.rstn    (rstn),
		.enable  (enable),
		.requests(rd_req),
		.grant   (rd_grant)
	);

	always_comb begin
		sel_cmd = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			if (rd_grant[i]) begin
				sel_cmd = cmd_head[i];
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_cmd_valid <= 1'b0;
		end else begin
			rd_cmd_valid <= |rd_grant;
		end
	end

	always_ff @(posedge clock) begin
		if (|rd_grant) begin
			rd_cmd_addr  <= sel_cmd.addr;
			rd_cmd_cu_id <= sel_cmd.cu_id;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Response routing and totals
	//////////////////////////////////////////////////////////////////////

	read_data_router #(
		.NUM_CU(NUM_CU)
	) u_router (
		.clock        (clock),
		.rstn         (rstn),
		.rd_resp_valid(rd_resp_valid),
		.rd_resp_cu_id(rd_resp_cu_id),
		.cu_resp_valid(cu_resp_valid)
	);

	progress_counters #(
		.NUM_CU(NUM_CU)
	) u_counters (
		.clock            (clock),
		.rstn             (rstn),
		.enable           (enable),
		.cu_done          (cu_done),
		.cu_done_edges    (cu_done_edges),
		.vertex_done_count(vertex_done_count),
		.edge_done_count  (edge_done_count)
	);

endmodule

`default_nettype wire

// ==== design/progress_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module progress_counters
	import graph_pkg::*;
#(
	parameter int NUM_CU = NUM_CU_DEFAULT
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enable,
	input  logic [NUM_CU-1:0]            cu_done,
	input  logic [NUM_CU*EDGE_CNT_W-1:0] cu_done_edges,
	output logic [DONE_W-1:0]            vertex_done_count,
	output logic [DONE_W-1:0]            edge_done_count
);

	logic [DONE_W-1:0] vertex_sum;
	logic [DONE_W-1:0] edge_sum;

	// Several CUs may finish in the same cycle
	always_comb begin
		vertex_sum = '0;
		edge_sum   = '0;
		for (int i = 0; i < NUM_CU; i++) begin
			if (cu_done[i]) begin
				vertex_sum = vertex_sum + 1'b1;
				edge_sum   = edge_sum + DONE_W'(cu_done_edges[i*EDGE_CNT_W +: EDGE_CNT_W]);
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else if (enable) begin
			vertex_done_count <= vertex_done_count + vertex_sum;
			edge_done_count   <= edge_done_count + edge_sum;
		end
	end

endmodule

`default_nettype wire

// ==== design/read_data_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_data_router
	import graph_pkg::*;
#(
	parameter int NUM_CU = NUM_CU_DEFAULT
) (
	input  logic               clock,
	input  logic               rstn,
	input  logic               rd_resp_valid,
	input  logic [CU_ID_W-1:0] rd_resp_cu_id,
	output logic [NUM_CU-1:0]  cu_resp_valid
);

	logic [NUM_CU-1:0] resp_decode;

	// One-hot by CU id
	always_comb begin
		for (int i = 0; i < NUM_CU; i++) begin
			resp_decode[i] = rd_resp_valid && (rd_resp_cu_id == CU_ID_W'(i));
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_resp_valid <= '0;
		end else begin
			cu_resp_valid <= resp_decode;
		end
	end

endmodule

`default_nettype wire

// ==== design/vertex_cu.sv ====
`timescale 1ns/1ps
`default_nettype none

module vertex_cu
	import graph_pkg::*;
(
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  enable,
	output logic                  job_req,
	input  logic                  job_grant,
	input  vertex_job_t           job,
	output logic                  cmd_valid,
	output logic [ADDR_W-1:0]     cmd_addr,
	input  logic                  cmd_full,
	input  logic                  resp_valid,
	output logic                  done,
	output logic [EDGE_CNT_W-1:0] done_edges
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT,
		FINISH
	} cu_state_t;

	cu_state_t             state;
	vertex_job_t           cur_job;
	logic [EDGE_CNT_W-1:0] issue_idx;
	logic [EDGE_CNT_W-1:0] ret_count;
	logic                  take_job;
	logic                  last_issue;

	//////////////////////////////////////////////////////////////////////
	// Datapath toward the command FIFO and the counters
	//////////////////////////////////////////////////////////////////////

	assign take_job   = enable && (state == IDLE) && job_grant;
	assign cmd_valid  = enable && (state == ISSUE) && !cmd_full;
	assign last_issue = (issue_idx + 1'b1 == cur_job.edge_count);
	assign cmd_addr   = cur_job.edge_start + ADDR_W'(issue_idx);
	assign done       = enable && (state == FINISH);
	assign done_edges = cur_job.edge_count;

	// Job held for the whole traversal of its edges
	always_ff @(posedge clock) begin
		if (take_job) begin
			cur_job <= job;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state     <= IDLE;
			job_req   <= 1'b0;
			issue_idx <= '0;
		end else if (enable) begin
			case (state)
				IDLE: begin
					job_req <= 1'b1;
					if (job_grant) begin
						job_req   <= 1'b0;
						issue_idx <= '0;
						// Vertex without edges has nothing to read
						state     <= (job.edge_count == '0) ? FINISH : ISSUE;
					end
				end
				ISSUE: begin
					if (cmd_valid) begin
						issue_idx <= issue_idx + 1'b1;
						if (last_issue) begin
							state <= WAIT;
						end
					end
				end
				WAIT: begin
					if (ret_count == cur_job.edge_count) begin
						state <= FINISH;
					end
				end
				FINISH: begin
					state   <= IDLE;
					job_req <= 1'b1;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Returns are counted in any state, even while frozen,
	// since reads already in the memory still come back
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ret_count <= '0;
		end else if (take_job) begin
			ret_count <= '0;
		end else if (resp_valid) begin
			ret_count <= ret_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== design/rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
	parameter int N           = 4,
	parameter int SLOT_PERIOD = 4
) (
	input  logic         clock,
	input  logic         rstn,
	input  logic         enable,
	input  logic [N-1:0] requests,
	output logic [N-1:0] grant
);

	localparam int CNT_W = (SLOT_PERIOD > 1) ? $clog2(SLOT_PERIOD) : 1;
	localparam int IDX_W = (N > 1) ? $clog2(N) : 1;

	logic [CNT_W-1:0] slot_cnt;
	logic [IDX_W-1:0] last_ptr;
	logic [IDX_W-1:0] grant_idx;
	logic             found;
	int               idx;

	// Search starts just past the last winner
	always_comb begin
		grant     = '0;
		grant_idx = last_ptr;
		found     = 1'b0;
		idx       = 0;
		if (enable && slot_cnt == '0) begin
			for (int off = 1; off <= N; off++) begin
				idx = (int'(last_ptr) + off) % N;
				if (!found && requests[idx]) begin
					found      = 1'b1;
					grant[idx] = 1'b1;
					grant_idx  = IDX_W'(idx);
				end
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			slot_cnt <= '0;
			// First winner is index 0
			last_ptr <= IDX_W'(N - 1);
		end else if (enable) begin
			slot_cnt <= (slot_cnt == CNT_W'(SLOT_PERIOD - 1)) ? '0 : slot_cnt + 1'b1;
			if (found) begin
				last_ptr <= grant_idx;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/job_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module job_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 8
) (
	input  logic     clock,
	input  logic     rstn,
	input  logic     push,
	input  payload_t data_in,
	input  logic     pop,
	output payload_t data_out,
	output logic     full,
	output logic     almost_full,
	output logic     empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Status from the fill count
	assign full        = (count == CNT_W'(DEPTH));
	assign almost_full = (count >= CNT_W'(DEPTH - 1));
	assign empty       = (count == '0);

	// Head entry is visible without a pop
	assign data_out = mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/graph_pkg.sv ====
`default_nettype none

package graph_pkg;

	// Field widths
	localparam int VERTEX_W   = 16;
	localparam int ADDR_W     = 32;
	localparam int EDGE_CNT_W = 8;
	localparam int CU_ID_W    = 3;
	localparam int DONE_W     = 32;

	// One vertex job as queued from the host
	typedef struct packed {
		logic [VERTEX_W-1:0]   vertex;
		logic [ADDR_W-1:0]     edge_start;
		logic [EDGE_CNT_W-1:0] edge_count;
	} vertex_job_t;

	// One edge read, tagged with its issuing CU
	typedef struct packed {
		logic [ADDR_W-1:0]  addr;
		logic [CU_ID_W-1:0] cu_id;
	} read_cmd_t;

	// Default sizing of the controller
	localparam int NUM_CU_DEFAULT    = 4;
	localparam int JOB_DEPTH_DEFAULT = 8;
	localparam int CMD_DEPTH_DEFAULT = 4;

	// Arbiter slot periods in cycles
	localparam int DISPATCH_PERIOD = 8;
	localparam int READ_PERIOD     = 4;

endpackage

`default_nettype wire
